// File: common/ifetch_defines.svh
`ifndef IFETCH_DEFINES_SVH
`define IFETCH_DEFINES_SVH

// First fetch address, also the redirect target after a bus error
`define IFETCH_RESET_PC 32'h3000_0000

// Instruction memory geometry
`define IMEM_DEPTH 64
`define IMEM_AW 6

// Cycles from AR accept to RVALID
`define IMEM_RD_LAT 2

`define AXI_ID_W 4

`endif

// File: common/axi_pkg.sv
package axi_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    // Single word beats only
    localparam logic [2:0] AXI_SIZE_4B     = 3'b010;
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;

endpackage

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [2:0] F3_BEQ     = 3'b000;

    // One instruction word, seen raw or through the J and B layouts
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
    } rv_insn_u;

endpackage

// File: ifu/ifu.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifu
    import axi_pkg::*, rv_isa_pkg::*;
(
    input  logic                 M_AXI_ACLK,
    input  logic                 ifu_rst,
    input  logic [31:0]          i_pc_next,
    input  logic                 i_pc_update,
    input  logic                 i_post_ready,
    output rv_insn_u             o_ins,
    output logic [31:0]          o_pc,
    output logic                 o_fetch_err,
    output logic                 o_post_valid,

    // Read address
    output logic [31:0]          M_AXI_ARADDR,
    output logic                 M_AXI_ARVALID,
    input  logic                 M_AXI_ARREADY,
    output logic [`AXI_ID_W-1:0] M_AXI_ARID,
    output logic [7:0]           M_AXI_ARLEN,
    output logic [2:0]           M_AXI_ARSIZE,
    output logic [1:0]           M_AXI_ARBURST,

    // Read data
    input  logic                 M_AXI_RVALID,
    output logic                 M_AXI_RREADY,
    input  logic [31:0]          M_AXI_RDATA,
    input  axi_resp_e            M_AXI_RRESP,
    input  logic [`AXI_ID_W-1:0] M_AXI_RID,
    input  logic                 M_AXI_RLAST,

    // Write side, never used by fetch
    output logic [31:0]          M_AXI_AWADDR,
    output logic                 M_AXI_AWVALID,
    input  logic                 M_AXI_AWREADY,
    output logic [7:0]           M_AXI_AWLEN,
    output logic [2:0]           M_AXI_AWSIZE,
    output logic [1:0]           M_AXI_AWBURST,
    output logic [`AXI_ID_W-1:0] M_AXI_AWID,
    output logic                 M_AXI_WVALID,
    input  logic                 M_AXI_WREADY,
    output logic [31:0]          M_AXI_WDATA,
    output logic [3:0]           M_AXI_WSTRB,
    output logic                 M_AXI_WLAST,
    input  logic                 M_AXI_BVALID,
    output logic                 M_AXI_BREADY,
    input  axi_resp_e            M_AXI_BRESP,
    input  logic [`AXI_ID_W-1:0] M_AXI_BID
);

    logic [31:0] pc;
    logic        start_q;
    logic        fetch_start;
    logic        ar_fire;
    logic        r_fire;

    assign M_AXI_AWADDR  = 32'h0;
    assign M_AXI_AWVALID = 1'b0;
    assign M_AXI_AWLEN   = 8'h0;
    assign M_AXI_AWSIZE  = 3'h0;
    assign M_AXI_AWBURST = 2'h0;
    assign M_AXI_AWID    = '0;
    assign M_AXI_WVALID  = 1'b0;
    assign M_AXI_WDATA   = 32'h0;
    assign M_AXI_WSTRB   = 4'h0;
    assign M_AXI_WLAST   = 1'b0;
    assign M_AXI_BREADY  = 1'b0;

    assign M_AXI_ARADDR  = pc;
    assign M_AXI_ARID    = '0;
    assign M_AXI_ARLEN   = 8'h0;
    assign M_AXI_ARSIZE  = AXI_SIZE_4B;
    assign M_AXI_ARBURST = AXI_BURST_FIXED;

    assign ar_fire = M_AXI_ARVALID && M_AXI_ARREADY;
    assign r_fire  = M_AXI_RVALID && M_AXI_RREADY;

    // Kick off once after reset, then once per update pulse
    assign fetch_start = start_q || i_pc_update;

    // ----------------------------------------------------------------------
    // PC and AR/R sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            start_q       <= 1'b1;
            pc            <= `IFETCH_RESET_PC;
            M_AXI_ARVALID <= 1'b0;
            M_AXI_RREADY  <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            if (i_pc_update)
                pc <= i_pc_next;
            if (fetch_start)
                M_AXI_ARVALID <= 1'b1;
            else if (ar_fire)
                M_AXI_ARVALID <= 1'b0;
            // Ready stays up for the whole wait on R
            if (ar_fire)
                M_AXI_RREADY <= 1'b1;
            else if (r_fire)
                M_AXI_RREADY <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Decode-side output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
            o_post_valid <= 1'b0;
        else if (r_fire)
            o_post_valid <= 1'b1;
        else if (o_post_valid && i_post_ready)
            o_post_valid <= 1'b0;
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (r_fire)
        begin
            o_ins.raw   <= M_AXI_RDATA;
            o_pc        <= pc;
            o_fetch_err <= (M_AXI_RRESP != RESP_OKAY);
        end
    end

    a_ar_stable: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR));

    a_post_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        o_post_valid && !i_post_ready |=> o_post_valid && $stable(o_ins) && $stable(o_pc)
            && $stable(o_fetch_err));

    // Only one fetch in flight
    a_no_early_update: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        i_pc_update |-> !(M_AXI_ARVALID || M_AXI_RREADY || o_post_valid));

    a_r_single_beat: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        r_fire |-> M_AXI_RLAST && (M_AXI_RID == '0));

endmodule

// File: verilog/pc_advance.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module pc_advance
    import rv_isa_pkg::*;
(
    input  logic        M_AXI_ACLK,
    input  logic        ifu_rst,
    input  rv_insn_u    i_ins,
    input  logic [31:0] i_pc,
    input  logic        i_fetch_err,
    input  logic        i_post_valid,
    input  logic        i_post_ready,
    output logic [31:0] o_pc_next,
    output logic        o_pc_update
);

    logic        handshake;
    logic [31:0] j_imm;
    logic [31:0] b_imm;
    logic [31:0] target;
    logic        beq_taken;

    assign handshake = i_post_valid && i_post_ready;

    // Sign-extended immediates
    assign j_imm = {{11{i_ins.j_fmt.imm20}}, i_ins.j_fmt.imm20, i_ins.j_fmt.imm19_12,
                    i_ins.j_fmt.imm11, i_ins.j_fmt.imm10_1, 1'b0};
    assign b_imm = {{19{i_ins.b_fmt.imm12}}, i_ins.b_fmt.imm12, i_ins.b_fmt.imm11,
                    i_ins.b_fmt.imm10_5, i_ins.b_fmt.imm4_1, 1'b0};

    // beq x,x is taken without a register read
    assign beq_taken = (i_ins.b_fmt.opcode == OPC_BRANCH)
                    && (i_ins.b_fmt.funct3 == F3_BEQ)
                    && (i_ins.b_fmt.rs1 == i_ins.b_fmt.rs2);

    always_comb
    begin
        if (i_fetch_err)
            target = `IFETCH_RESET_PC;
        else if (i_ins.j_fmt.opcode == OPC_JAL)
            target = i_pc + j_imm;
        else if (beq_taken)
            target = i_pc + b_imm;
        else
            target = i_pc + 32'd4;
    end

    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
            o_pc_update <= 1'b0;
        else
            o_pc_update <= handshake;
    end

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (handshake)
            o_pc_next <= target;
    end

    a_update_pulse: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        o_pc_update |=> !o_pc_update);

endmodule

// File: verilog/axi_imem.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module axi_imem
    import axi_pkg::*;
(
    input  logic                 M_AXI_ACLK,
    input  logic                 ifu_rst,

    input  logic [31:0]          M_AXI_ARADDR,
    input  logic                 M_AXI_ARVALID,
    output logic                 M_AXI_ARREADY,
    input  logic [`AXI_ID_W-1:0] M_AXI_ARID,
    input  logic [7:0]           M_AXI_ARLEN,
    input  logic [2:0]           M_AXI_ARSIZE,
    input  logic [1:0]           M_AXI_ARBURST,

    output logic                 M_AXI_RVALID,
    input  logic                 M_AXI_RREADY,
    output logic [31:0]          M_AXI_RDATA,
    output axi_resp_e            M_AXI_RRESP,
    output logic [`AXI_ID_W-1:0] M_AXI_RID,
    output logic                 M_AXI_RLAST,

    input  logic                 i_load_en,
    input  logic [`IMEM_AW-1:0]  i_load_addr,
    input  logic [31:0]          i_load_data
);

    logic [31:0]         mem [`IMEM_DEPTH];
    logic                busy;
    logic [1:0]          lat_cnt;
    logic [31:0]         ar_off;
    logic [`IMEM_AW-1:0] ar_idx;
    logic                rd_ok;
    logic                ar_fire;

    assign M_AXI_ARREADY = !busy;
    assign M_AXI_RLAST   = 1'b1;
    assign ar_fire       = M_AXI_ARVALID && M_AXI_ARREADY;

    // Window check, aligned single-word beats only
    assign ar_off = M_AXI_ARADDR - `IFETCH_RESET_PC;
    assign ar_idx = ar_off[`IMEM_AW+1:2];
    assign rd_ok  = (ar_off[31:`IMEM_AW+2] == '0) && (ar_off[1:0] == 2'b00)
                 && (M_AXI_ARLEN == 8'h0) && (M_AXI_ARSIZE == AXI_SIZE_4B)
                 && (M_AXI_ARBURST == AXI_BURST_FIXED);

    always_ff @(posedge M_AXI_ACLK)
    begin
        if (i_load_en)
            mem[i_load_addr] <= i_load_data;
    end

    // ----------------------------------------------------------------------
    // Fixed-latency response
    // ----------------------------------------------------------------------
    always_ff @(posedge M_AXI_ACLK or negedge ifu_rst)
    begin
        if (!ifu_rst)
        begin
            busy         <= 1'b0;
            lat_cnt      <= 2'd0;
            M_AXI_RVALID <= 1'b0;
        end
        else if (ar_fire)
        begin
            busy    <= 1'b1;
            lat_cnt <= 2'(`IMEM_RD_LAT - 1);
        end
        else if (M_AXI_RVALID && M_AXI_RREADY)
        begin
            busy         <= 1'b0;
            M_AXI_RVALID <= 1'b0;
        end
        else if (busy && !M_AXI_RVALID)
        begin
            if (lat_cnt == 2'd0)
                M_AXI_RVALID <= 1'b1;
            else
                lat_cnt <= lat_cnt - 2'd1;
        end
    end

    // Word and response latched at address accept
    always_ff @(posedge M_AXI_ACLK)
    begin
        if (ar_fire)
        begin
            M_AXI_RDATA <= rd_ok ? mem[ar_idx] : 32'h0;
            M_AXI_RRESP <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            M_AXI_RID   <= M_AXI_ARID;
        end
    end

    a_r_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!ifu_rst)
        M_AXI_RVALID && !M_AXI_RREADY |=> M_AXI_RVALID && $stable(M_AXI_RDATA));

endmodule

// File: verilog/ifetch_top.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module ifetch_top
    import axi_pkg::*, rv_isa_pkg::*;
(
    input  logic                M_AXI_ACLK,
    input  logic                ifu_rst,
    input  logic                i_post_ready,
    input  logic                i_load_en,
    input  logic [`IMEM_AW-1:0] i_load_addr,
    input  logic [31:0]         i_load_data,
    output rv_insn_u            o_ins,
    output logic [31:0]         o_pc,
    output logic                o_fetch_err,
    output logic                o_post_valid
);

    logic [31:0]          araddr;
    logic                 arvalid;
    logic                 arready;
    logic [`AXI_ID_W-1:0] arid;
    logic [7:0]           arlen;
    logic [2:0]           arsize;
    logic [1:0]           arburst;
    logic                 rvalid;
    logic                 rready;
    logic [31:0]          rdata;
    axi_resp_e            rresp;
    logic [`AXI_ID_W-1:0] rid;
    logic                 rlast;
    logic [31:0]          pc_next;
    logic                 pc_update;

    ifu u_ifu (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .ifu_rst       (ifu_rst),
        .i_pc_next     (pc_next),
        .i_pc_update   (pc_update),
        .i_post_ready  (i_post_ready),
        .o_ins         (o_ins),
        .o_pc          (o_pc),
        .o_fetch_err   (o_fetch_err),
        .o_post_valid  (o_post_valid),
        .M_AXI_ARADDR  (araddr),
        .M_AXI_ARVALID (arvalid),
        .M_AXI_ARREADY (arready),
        .M_AXI_ARID    (arid),
        .M_AXI_ARLEN   (arlen),
        .M_AXI_ARSIZE  (arsize),
        .M_AXI_ARBURST (arburst),
        .M_AXI_RVALID  (rvalid),
        .M_AXI_RREADY  (rready),
        .M_AXI_RDATA   (rdata),
        .M_AXI_RRESP   (rresp),
        .M_AXI_RID     (rid),
        .M_AXI_RLAST   (rlast),
        // Write side ends here
        .M_AXI_AWADDR  (),
        .M_AXI_AWVALID (),
        .M_AXI_AWREADY (1'b0),
        .M_AXI_AWLEN   (),
        .M_AXI_AWSIZE  (),
        .M_AXI_AWBURST (),
        .M_AXI_AWID    (),
        .M_AXI_WVALID  (),
        .M_AXI_WREADY  (1'b0),
        .M_AXI_WDATA   (),
        .M_AXI_WSTRB   (),
        .M_AXI_WLAST   (),
        .M_AXI_BVALID  (1'b0),
        .M_AXI_BREADY  (),
        .M_AXI_BRESP   (RESP_OKAY),
        .M_AXI_BID     ('0)
    );

    pc_advance u_pc_advance (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .ifu_rst      (ifu_rst),
        .i_ins        (o_ins),
        .i_pc         (o_pc),
        .i_fetch_err  (o_fetch_err),
        .i_post_valid (o_post_valid),
        .i_post_ready (i_post_ready),
        .o_pc_next    (pc_next),
        .o_pc_update  (pc_update)
    );

    axi_imem u_axi_imem (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .ifu_rst       (ifu_rst),
        .M_AXI_ARADDR  (araddr),
        .M_AXI_ARVALID (arvalid),
        .M_AXI_ARREADY (arready),
        .M_AXI_ARID    (arid),
        .M_AXI_ARLEN   (arlen),
        .M_AXI_ARSIZE  (arsize),
        .M_AXI_ARBURST (arburst),
        .M_AXI_RVALID  (rvalid),
        .M_AXI_RREADY  (rready),
        .M_AXI_RDATA   (rdata),
        .M_AXI_RRESP   (rresp),
        .M_AXI_RID     (rid),
        .M_AXI_RLAST   (rlast),
        .i_load_en     (i_load_en),
        .i_load_addr   (i_load_addr),
        .i_load_data   (i_load_data)
    );

endmodule

// File: testbench/tb_ifetch.sv
`timescale 1ns/1ns
`include "ifetch_defines.svh"

module tb_ifetch
    import rv_isa_pkg::*;
();

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 16;
    localparam int N_HANDSHAKES = 400;
    localparam int FETCH_LAT    = 3 + `IMEM_RD_LAT;
    localparam int SETUP_CYCLES = `IMEM_DEPTH + RESET_CYCLES + 4;
    localparam int WDOG_CYCLES  = N_HANDSHAKES * (FETCH_LAT + 20) + SETUP_CYCLES;

    // Program word kinds
    localparam logic [1:0] K_PLAIN     = 2'd0;
    localparam logic [1:0] K_JAL       = 2'd1;
    localparam logic [1:0] K_BEQ_TAKEN = 2'd2;
    localparam logic [1:0] K_BEQ_NOT   = 2'd3;
    localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;

    logic                M_AXI_ACLK = 1'b0;
    logic                ifu_rst;
    logic                i_post_ready;
    logic                i_load_en;
    logic [`IMEM_AW-1:0] i_load_addr;
    logic [31:0]         i_load_data;
    rv_insn_u            o_ins;
    logic [31:0]         o_pc;
    logic                o_fetch_err;
    logic                o_post_valid;

    logic [31:0] rng_state = 32'h2e83;
    rv_insn_u    mdl_mem [`IMEM_DEPTH];
    logic [1:0]  mdl_kind [`IMEM_DEPTH];
    logic [31:0] mdl_off [`IMEM_DEPTH];
    logic [31:0] model_pc;
    int          hs_count = 0;
    int          n_jumps = 0;
    int          n_errs = 0;
    bit          running = 1'b0;
    bit          holding = 1'b0;

    ifetch_top u_ifetch_top (
        .M_AXI_ACLK   (M_AXI_ACLK),
        .ifu_rst      (ifu_rst),
        .i_post_ready (i_post_ready),
        .i_load_en    (i_load_en),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .o_ins        (o_ins),
        .o_pc         (o_pc),
        .o_fetch_err  (o_fetch_err),
        .o_post_valid (o_post_valid)
    );

    always #(CLK_HALF) M_AXI_ACLK = ~M_AXI_ACLK;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic bit in_window(input logic [31:0] pc);
        logic [31:0] off;
        off = pc - `IFETCH_RESET_PC;
        return (off < 32'(4 * `IMEM_DEPTH)) && (off[1:0] == 2'b00);
    endfunction

    // Word the memory returns for a PC, zero outside the window
    function automatic rv_insn_u expected_insn(input logic [31:0] pc);
        rv_insn_u w;
        w.raw = 32'h0;
        if (in_window(pc))
            w = mdl_mem[(pc - `IFETCH_RESET_PC) >> 2];
        return w;
    endfunction

    // Next PC from the kind and offset chosen when the word was built
    function automatic logic [31:0] model_next(input logic [31:0] pc);
        int unsigned idx;
        if (!in_window(pc))
            return `IFETCH_RESET_PC;
        idx = (pc - `IFETCH_RESET_PC) >> 2;
        if (mdl_kind[idx] == K_JAL || mdl_kind[idx] == K_BEQ_TAKEN)
            return pc + mdl_off[idx];
        return pc + 32'd4;
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_insn(input rv_insn_u got, input rv_insn_u exp, input string what);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s o_ins got %h expected %h", $time, what, got.raw,
                     exp.raw);
            abort_run();
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s o_pc got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s o_fetch_err got %b expected %b", $time, what, got,
                     exp);
            abort_run();
        end
    endtask

    // Targets only go forward so every pass ends at word 63 and its jump out of the window
    task automatic build_program();
        int unsigned idx;
        int unsigned tgt;
        logic [31:0] r;
        logic [31:0] off;
        logic [1:0]  kind;
        rv_insn_u    w;
        for (idx = 0; idx < `IMEM_DEPTH; idx++)
        begin
            r = next_rand();
            if (idx == `IMEM_DEPTH - 1)
            begin
                kind = K_JAL;
                off  = 32'(4 * (1 + r[5:0]));
            end
            else
            begin
                kind = r[1:0];
                tgt  = idx + 1 + (r[31:8] % (`IMEM_DEPTH - 1 - idx));
                off  = 32'(4 * (tgt - idx));
            end
            w.raw = next_rand();
            case (kind)
                K_PLAIN:
                    w.raw[6:0] = OPC_OP_IMM;
                K_JAL:
                begin
                    w.j_fmt.opcode   = OPC_JAL;
                    w.j_fmt.imm20    = off[20];
                    w.j_fmt.imm19_12 = off[19:12];
                    w.j_fmt.imm11    = off[11];
                    w.j_fmt.imm10_1  = off[10:1];
                end
                K_BEQ_TAKEN, K_BEQ_NOT:
                begin
                    w.b_fmt.opcode  = OPC_BRANCH;
                    w.b_fmt.funct3  = F3_BEQ;
                    w.b_fmt.imm12   = off[12];
                    w.b_fmt.imm11   = off[11];
                    w.b_fmt.imm10_5 = off[10:5];
                    w.b_fmt.imm4_1  = off[4:1];
                    if (kind == K_BEQ_TAKEN)
                        w.b_fmt.rs2 = w.b_fmt.rs1;
                    else
                        w.b_fmt.rs2 = w.b_fmt.rs1 ^ 5'(1 + (r[12:8] % 31));
                end
            endcase
            mdl_mem[idx]  = w;
            mdl_kind[idx] = kind;
            mdl_off[idx]  = off;
        end
    endtask

    task automatic load_program();
        int idx;
        for (idx = 0; idx < `IMEM_DEPTH; idx++)
        begin
            @(posedge M_AXI_ACLK);
            #1;
            i_load_en   = 1'b1;
            i_load_addr = `IMEM_AW'(idx);
            i_load_data = mdl_mem[idx].raw;
        end
        @(posedge M_AXI_ACLK);
        #1;
        i_load_en = 1'b0;
    endtask

    task automatic record_handshake();
        int unsigned idx;
        if (in_window(model_pc))
        begin
            idx = (model_pc - `IFETCH_RESET_PC) >> 2;
            if (mdl_kind[idx] == K_JAL || mdl_kind[idx] == K_BEQ_TAKEN)
                n_jumps++;
        end
        else
            n_errs++;
        check_pc(o_pc, model_pc, "handshake");
        check_err(o_fetch_err, !in_window(model_pc), "handshake");
        check_insn(o_ins, expected_insn(model_pc), "handshake");
        model_pc = model_next(model_pc);
        hs_count++;
    endtask

    // ------------------------------------------------------------------
    // Monitor on the falling edge where outputs and ready are settled
    // ------------------------------------------------------------------
    always @(negedge M_AXI_ACLK)
    begin
        if (running)
        begin
            if (holding)
            begin
                if (o_post_valid !== 1'b1)
                begin
                    $display("o_post_valid fell at %0t while ready was low", $time);
                    abort_run();
                end
                check_insn(o_ins, expected_insn(model_pc), "stalled");
                check_pc(o_pc, model_pc, "stalled");
                check_err(o_fetch_err, !in_window(model_pc), "stalled");
            end
            holding = o_post_valid && !i_post_ready;
            if (o_post_valid && i_post_ready)
                record_handshake();
        end
    end

    initial
    begin
        repeat (WDOG_CYCLES) @(posedge M_AXI_ACLK);
        $display("Fetch stopped making progress after %0d handshakes", hs_count);
        abort_run();
    end

    initial
    begin
        ifu_rst      = 1'b0;
        i_post_ready = 1'b0;
        i_load_en    = 1'b0;
        i_load_addr  = '0;
        i_load_data  = 32'h0;
        model_pc     = `IFETCH_RESET_PC;
        build_program();
        // Program goes in while fetch is held in reset
        load_program();
        repeat (RESET_CYCLES) @(posedge M_AXI_ACLK);
        #1;
        ifu_rst = 1'b1;
        running = 1'b1;
        while (hs_count < N_HANDSHAKES)
        begin
            @(posedge M_AXI_ACLK);
            #1;
            i_post_ready = (next_rand() % 16) < 10;
        end
        if (n_errs == 0 || n_jumps == 0)
        begin
            $display("Run never saw both a taken jump and a fetch error");
            abort_run();
        end
        else
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: tb.f
+incdir+common
common/axi_pkg.sv
common/rv_isa_pkg.sv
ifu/ifu.sv
verilog/pc_advance.sv
verilog/axi_imem.sv
verilog/ifetch_top.sv
testbench/tb_ifetch.sv

// File: Bender.yml
package:
  name: ifetch

sources:
  - include_dirs:
      - common
    files:
      - common/axi_pkg.sv
      - common/rv_isa_pkg.sv
      - ifu/ifu.sv
      - verilog/pc_advance.sv
      - verilog/axi_imem.sv
      - verilog/ifetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_ifetch.sv
